//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_soc_io
FILELIST  = soc_io.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_soc_io.sv
module tb_soc_io import soc_io_pkg::*; ();

  localparam longint CLK_PERIOD   = 100;
  localparam int     RESET_CYCLES = 3;
  localparam int     RAM_N        = 32;   // Random RAM locations
  localparam int     MODE_ITERS   = 4;    // Writes per mode per register
  localparam int     GPIO_IN_N    = 4;
  localparam word_t  RELOAD_VAL   = 32'hFFFF_FF00;
  localparam word_t  TICKS_START  = 32'hFFFF_FFF0;
  localparam int     FIRST_IRQ_CYCLES  = 16;    // 0xFFFFFFF0 up to the wrap
  localparam int     IRQ_PERIOD_CYCLES = 256;   // 2**32 - reload
  localparam int     IRQ_PULSES        = 4;
  // Rough cycle budget of every test with two cycles per access
  localparam int     TOTAL_CYCLES = RESET_CYCLES + 20 + RAM_N * 6 + 16
                                    + 4 * 4 * MODE_ITERS * 5 + GPIO_IN_N * 3
                                    + 12 + FIRST_IRQ_CYCLES
                                    + IRQ_PERIOD_CYCLES * (IRQ_PULSES - 1) + 8;
  localparam longint WATCHDOG_TIME = longint'(TOTAL_CYCLES + 200) * CLK_PERIOD;
  localparam wmask_t LEGAL_MASKS [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                         4'b0011, 4'b1100, 4'b1111};

  logic clk = 1'b0;
  logic reset;
  word_t address;
  word_t wdata;
  wmask_t wmask;
  logic rstrb;
  word_t rdata;
  logic interrupt;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_dir;
  logic [LED_WIDTH-1:0] leds;
  logic [ANALOG_WIDTH-1:0] analog_out;

  logic [15:0] lfsr_state = 16'd11;
  word_t exp_q[$];            // Expected read data in issue order
  string name_q[$];
  logic rd_valid = 1'b0;      // rdata due this cycle
  word_t sh_ram [int];        // Shadow RAM by word index
  word_t sh_out;
  word_t sh_dir;
  word_t sh_leds;
  word_t sh_analog;
  int checks = 0;
  int mismatches = 0;
  int other_errors = 0;
  longint write_edge;         // Edge that took the last write
  longint ticks_write_edge;
  longint last_irq_edge;
  longint pulse_edge;
  bit timer_armed = 1'b0;
  bit irq_prev = 1'b0;
  int irq_count = 0;

  soc_io_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .address    (address),
    .wdata      (wdata),
    .wmask      (wmask),
    .rstrb      (rstrb),
    .rdata      (rdata),
    .interrupt  (interrupt),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .gpio_dir   (gpio_dir),
    .leds       (leds),
    .analog_out (analog_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};   // One step per bit
    end
    return r;
  endfunction

  function automatic wmask_t rand_mask();
    int k;
    k = int'(rand_bits(3)) % 7;
    return LEGAL_MASKS[k];
  endfunction

  function automatic word_t field_mask(input int width);
    return (width >= 32) ? '1 : (word_t'(1) << width) - word_t'(1);
  endfunction

  // Expected value after a masked write in the given mode
  function automatic word_t ref_io_write(input word_t old_val, input word_t data,
                                         input wmask_t mask, input io_mode_t mode);
    word_t merged;
    word_t res;
    case (mode)
      MODE_WRITE: merged = data;
      MODE_CLEAR: merged = old_val & ~data;
      MODE_SET:   merged = old_val | data;
      default:    merged = old_val ^ data;   // Toggle
    endcase
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (mask[b])
        res[b*8 +: 8] = merged[b*8 +: 8];   // Unmasked bytes keep old data
    end
    return res;
  endfunction

  function automatic word_t io_addr(input int sel_bit, input io_mode_t mode);
    return 32'h4000_0000 | (word_t'(1) << sel_bit) | (word_t'(mode) << MODE_LSB);
  endfunction

  function automatic word_t port_value(input int sel_bit);
    case (sel_bit)
      IO_GPIO_OUT_BIT:   return word_t'(gpio_out);
      IO_GPIO_DIR_BIT:   return word_t'(gpio_dir);
      IO_LEDS_BIT:       return word_t'(leds);
      IO_ANALOG_OUT_BIT: return word_t'(analog_out);
      default:           return '0;
    endcase
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t expected);
    checks++;
    if (got !== expected) begin
      mismatches++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
    end
  endtask

  task automatic check_period(input string name, input int got, input int expected);
    checks++;
    if (got != expected) begin
      mismatches++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
    end
  endtask

  task automatic bus_write(input word_t a, input word_t d, input wmask_t m);
    @(posedge clk);
    address <= a;
    wdata   <= d;
    wmask   <= m;
    rstrb   <= 1'b0;
    @(posedge clk);
    wmask      <= '0;
    write_edge = $time;   // Write taken here
  endtask

  task automatic bus_read(input word_t a, input word_t expected, input string name);
    @(posedge clk);
    address <= a;
    wmask   <= '0;
    rstrb   <= 1'b1;
    exp_q.push_back(expected);
    name_q.push_back(name);
    @(posedge clk);
    rstrb <= 1'b0;
  endtask

  // Write in every mode, then check port and readback
  task automatic reg_mode_test(input string name, input int sel_bit, input int width,
                               input bit byte_masked, input word_t old_val,
                               output word_t new_val);
    word_t cur;
    word_t data;
    wmask_t mask;
    cur = old_val;
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < MODE_ITERS; i++) begin
        data = rand_bits(32);
        mask = rand_mask();
        cur = ref_io_write(cur, data, byte_masked ? mask : 4'hF, io_mode_t'(m))
              & field_mask(width);
        bus_write(io_addr(sel_bit, io_mode_t'(m)), data, mask);
        @(negedge clk);
        check_word({name, " port"}, port_value(sel_bit), cur);
        bus_read(io_addr(sel_bit, MODE_WRITE), cur, {name, " rdata"});
      end
    end
    new_val = cur;
  endtask

  always @(posedge clk) rd_valid <= rstrb;   // Same sample as the DUT

  // Read data compare half a cycle after the capture edge
  always @(negedge clk) begin
    if (rd_valid) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Read data came back with no read outstanding");
      end else begin
        check_word(name_q.pop_front(), rdata, exp_q.pop_front());
      end
    end
  end

  // Interrupt width and spacing
  always @(negedge clk) begin
    if (!reset && interrupt) begin
      if (irq_prev) begin
        other_errors++;
        $display("Interrupt stayed high for more than one cycle");
      end else if (!timer_armed) begin
        other_errors++;
        $display("Interrupt fired before the timer was set up");
      end else begin
        pulse_edge = $time - CLK_PERIOD / 2;
        if (irq_count == 0)
          check_period("first interrupt delay",
                       int'((pulse_edge - ticks_write_edge) / CLK_PERIOD), FIRST_IRQ_CYCLES);
        else
          check_period("interrupt period",
                       int'((pulse_edge - last_irq_edge) / CLK_PERIOD), IRQ_PERIOD_CYCLES);
        last_irq_edge = pulse_edge;
        irq_count++;
      end
    end
    irq_prev = interrupt;
  end

  initial begin
    #(WATCHDOG_TIME);
    other_errors++;
    $display("Watchdog expired after %0d cycles, the tests did not finish", TOTAL_CYCLES + 200);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errors);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int idx_q[$];
    int idx;
    word_t data;
    wmask_t mask;
    word_t pins;
    reset   = 1'b1;
    address = '0;
    wdata   = '0;
    wmask   = '0;
    rstrb   = 1'b0;
    gpio_in = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Ticks cleared at release and counted once by the capture edge
    bus_read(io_addr(IO_TICKS_BIT, MODE_WRITE), 32'd1, "ticks after reset");
    bus_read(io_addr(IO_RELOAD_BIT, MODE_WRITE), '0, "reload after reset");
    bus_read(io_addr(IO_GPIO_OUT_BIT, MODE_WRITE), '0, "gpio_out after reset");
    bus_read(io_addr(IO_GPIO_DIR_BIT, MODE_WRITE), '0, "gpio_dir after reset");
    bus_read(io_addr(IO_LEDS_BIT, MODE_WRITE), '0, "leds after reset");
    bus_read(io_addr(IO_ANALOG_OUT_BIT, MODE_WRITE), '0, "analog_out after reset");
    @(negedge clk);
    check_word("interrupt after reset", word_t'(interrupt), '0);
    sh_out = '0;
    sh_dir = '0;
    sh_leds = '0;
    sh_analog = '0;

    // Full word first so no RAM byte stays unknown
    for (int i = 0; i < RAM_N; i++) begin
      idx = int'(rand_bits(RAM_ADDR_BITS));
      idx_q.push_back(idx);
      data = rand_bits(32);
      bus_write(word_t'(idx) << 2, data, 4'hF);
      sh_ram[idx] = data;
      data = rand_bits(32);
      mask = rand_mask();
      bus_write(word_t'(idx) << 2, data, mask);
      sh_ram[idx] = ref_io_write(sh_ram[idx], data, mask, MODE_WRITE);
    end
    // Unmapped pages alias live RAM words in their low bits
    bus_write(32'h8000_0000 | (word_t'(idx_q[0]) << 2), rand_bits(32), 4'hF);
    bus_write(32'hC000_0000 | (word_t'(idx_q[1]) << 2), rand_bits(32), 4'hF);
    foreach (idx_q[i])
      bus_read(word_t'(idx_q[i]) << 2, sh_ram[idx_q[i]], "ram rdata");
    bus_read(32'h8000_0000 | (word_t'(idx_q[0]) << 2), '0, "flash page rdata");
    bus_read(32'hC000_0000 | (word_t'(idx_q[1]) << 2), '0, "sdram page rdata");

    reg_mode_test("leds", IO_LEDS_BIT, LED_WIDTH, 1'b0, sh_leds, sh_leds);
    reg_mode_test("analog_out", IO_ANALOG_OUT_BIT, ANALOG_WIDTH, 1'b0, sh_analog, sh_analog);
    reg_mode_test("gpio_out", IO_GPIO_OUT_BIT, GPIO_WIDTH, 1'b1, sh_out, sh_out);
    reg_mode_test("gpio_dir", IO_GPIO_DIR_BIT, GPIO_WIDTH, 1'b1, sh_dir, sh_dir);

    for (int i = 0; i < GPIO_IN_N; i++) begin
      pins = rand_bits(GPIO_WIDTH);
      @(posedge clk);
      gpio_in <= pins[GPIO_WIDTH-1:0];
      bus_read(io_addr(IO_GPIO_IN_BIT, MODE_WRITE), pins, "gpio_in rdata");
    end

    // Clear mode address but the timer still takes raw data
    bus_write(io_addr(IO_RELOAD_BIT, MODE_CLEAR), RELOAD_VAL, 4'hF);
    bus_read(io_addr(IO_RELOAD_BIT, MODE_WRITE), RELOAD_VAL, "reload");
    bus_write(io_addr(IO_TICKS_BIT, MODE_WRITE), TICKS_START, 4'hF);
    ticks_write_edge = write_edge;
    timer_armed = 1'b1;
    while (irq_count < IRQ_PULSES)
      @(posedge clk);
    repeat (3) @(negedge clk);   // Last pulse width and last compare

    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d reads never returned data", exp_q.size());
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errors);
    if (mismatches + other_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- soc_io.f
verilog/soc_io_pkg.sv
verilog/bus_control.sv
verilog/ram_block.sv
verilog/gpio_regs.sv
verilog/io_timer.sv
verilog/soc_io_top.sv
sim/tb_soc_io.sv

//--- verilog/bus_control.sv
module bus_control import soc_io_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  // Processor side
  input  word_t                    address,
  input  word_t                    wdata,
  input  wmask_t                   wmask,
  input  logic                     rstrb,
  output word_t                    rdata,
  // RAM side
  output wmask_t                   ram_we,
  output logic [RAM_ADDR_BITS-1:0] ram_addr,
  output word_t                    ram_wdata,
  input  word_t                    ram_rdata,
  // I/O register side
  output word_t                    io_sel,
  output wmask_t                   io_wmask,
  output word_t                    io_wdata_mod,
  input  logic [GPIO_WIDTH-1:0]    gpio_in,
  input  logic [GPIO_WIDTH-1:0]    gpio_out,
  input  logic [GPIO_WIDTH-1:0]    gpio_dir,
  input  logic [LED_WIDTH-1:0]     leds,
  input  logic [ANALOG_WIDTH-1:0]  analog_out,
  input  word_t                    ticks,
  input  word_t                    reload
);

  mem_page_t page;        // Page of current address
  mem_page_t rd_page;     // Page captured with the read
  io_mode_t  mode;
  logic      wstrb;       // Any byte written
  word_t     io_rdata;    // Combinational OR mux
  word_t     io_rdata_q;  // Read buffer

  assign page  = mem_page_t'(address[PAGE_MSB:PAGE_LSB]);
  assign mode  = io_mode_t'(address[MODE_MSB:MODE_LSB]);
  assign wstrb = |wmask;

  // RAM gets byte enables only inside its page
  assign ram_we    = (page == PAGE_RAM) ? wmask : '0;
  assign ram_addr  = address[WORD_LSB +: RAM_ADDR_BITS];
  assign ram_wdata = wdata;

  // One-hot selects qualified by page and write strobe
  assign io_sel   = (page == PAGE_IO && wstrb) ? address : '0;
  assign io_wmask = wmask;

  // Several selected registers simply OR together
  assign io_rdata =
    (address[IO_GPIO_IN_BIT]    ? word_t'(gpio_in)    : '0) |
    (address[IO_GPIO_OUT_BIT]   ? word_t'(gpio_out)   : '0) |
    (address[IO_GPIO_DIR_BIT]   ? word_t'(gpio_dir)   : '0) |
    (address[IO_LEDS_BIT]       ? word_t'(leds)       : '0) |
    (address[IO_ANALOG_OUT_BIT] ? word_t'(analog_out) : '0) |
    (address[IO_TICKS_BIT]      ? ticks               : '0) |
    (address[IO_RELOAD_BIT]     ? reload              : '0);

  // Read-modify-write against the current register value
  always_comb begin
    unique case (mode)
      MODE_CLEAR:  io_wdata_mod = io_rdata & ~wdata;
      MODE_SET:    io_wdata_mod = io_rdata | wdata;
      MODE_TOGGLE: io_wdata_mod = io_rdata ^ wdata;
      default:     io_wdata_mod = wdata;            // MODE_WRITE
    endcase
  end

  // I/O data held for the cycle after rstrb, like the RAM output
  always_ff @(posedge clk) begin
    if (reset) begin
      io_rdata_q <= '0;
      rd_page    <= PAGE_FLASH;   // Unmapped page, rdata is zero until first read
    end else if (rstrb) begin
      rd_page <= page;
      if (page == PAGE_IO)
        io_rdata_q <= io_rdata;
    end
  end

  // Return path follows the page of the last read
  always_comb begin
    case (rd_page)
      PAGE_RAM: rdata = ram_rdata;
      PAGE_IO:  rdata = io_rdata_q;
      default:  rdata = '0;          // Flash and SDRAM pages
    endcase
  end

  // Processor only issues byte, halfword or word stores
  a_wmask_legal: assert property (@(posedge clk) disable iff (reset)
    wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                  4'b0011, 4'b1100, 4'b1111});

  // Read and write never in the same cycle
  a_no_rw_overlap: assert property (@(posedge clk) disable iff (reset)
    !(rstrb && wstrb));

endmodule

//--- verilog/gpio_regs.sv
module gpio_regs import soc_io_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  word_t                   io_sel,        // One-hot, write qualified
  input  wmask_t                  io_wmask,
  input  word_t                   io_wdata_mod,  // Value after write mode
  output logic [GPIO_WIDTH-1:0]   gpio_out,
  output logic [GPIO_WIDTH-1:0]   gpio_dir,      // 1 means pin driven
  output logic [LED_WIDTH-1:0]    leds,
  output logic [ANALOG_WIDTH-1:0] analog_out     // {ch2, ch1, ch0}
);

  logic sel_out;
  logic sel_dir;
  logic sel_leds;
  logic sel_analog;

  assign sel_out    = io_sel[IO_GPIO_OUT_BIT];
  assign sel_dir    = io_sel[IO_GPIO_DIR_BIT];
  assign sel_leds   = io_sel[IO_LEDS_BIT];
  assign sel_analog = io_sel[IO_ANALOG_OUT_BIT];

  // Merge new data into old, one byte lane per mask bit
  function automatic logic [GPIO_WIDTH-1:0] byte_merge(
    input logic [GPIO_WIDTH-1:0] old_val,
    input word_t                 new_val,
    input wmask_t                mask
  );
    logic [GPIO_WIDTH-1:0] res;
    res = old_val;
    for (int i = 0; i < GPIO_WIDTH; i++) begin
      if (mask[i / 8])
        res[i] = new_val[i];   // Top lane only 4 bits wide
    end
    return res;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out   <= '0;
      gpio_dir   <= '0;   // All pins inputs
      leds       <= '0;
      analog_out <= '0;
    end else begin
      if (sel_out)
        gpio_out <= byte_merge(gpio_out, io_wdata_mod, io_wmask);
      if (sel_dir)
        gpio_dir <= byte_merge(gpio_dir, io_wdata_mod, io_wmask);
      // Whole register on any store width
      if (sel_leds)
        leds <= io_wdata_mod[LED_WIDTH-1:0];
      if (sel_analog)
        analog_out <= io_wdata_mod[ANALOG_WIDTH-1:0];
    end
  end

  // Software writes one register at a time
  a_one_reg_per_write: assert property (@(posedge clk) disable iff (reset)
    (|io_sel) |-> $onehot0({sel_out, sel_dir, sel_leds, sel_analog}));

endmodule

//--- verilog/io_timer.sv
module io_timer import soc_io_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t io_sel,     // One-hot, write qualified
  input  word_t wdata,      // Raw bus data, write mode not applied
  output word_t ticks,
  output word_t reload,
  output logic  interrupt   // One cycle after wrap
);

  logic  wrap;        // Counter at all ones
  word_t next_ticks;

  assign wrap       = &ticks;
  assign next_ticks = wrap ? reload : ticks + 32'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      ticks     <= '0;
      reload    <= '0;
      interrupt <= 1'b0;
    end else begin
      if (io_sel[IO_TICKS_BIT])
        ticks <= wdata;           // Software write wins over count
      else
        ticks <= next_ticks;
      if (io_sel[IO_RELOAD_BIT])
        reload <= wdata;
      interrupt <= wrap;          // Flag even when ticks is overwritten
    end
  end

  // Period is 2**32 - reload, so pulses stay apart unless reload is all ones
  // or software reloads ticks with all ones right at the wrap
  a_irq_single_pulse: assert property (@(posedge clk) disable iff (reset)
    interrupt && !(&reload) && !$past(io_sel[IO_TICKS_BIT]) |=> !interrupt);

endmodule

//--- verilog/ram_block.sv
module ram_block import soc_io_pkg::*; (
  input  logic                     clk,
  input  wmask_t                   ram_we,     // Per-byte write enables
  input  logic [RAM_ADDR_BITS-1:0] ram_addr,   // Word address
  input  word_t                    ram_wdata,
  output word_t                    ram_rdata
);

  localparam int DEPTH = 2 ** RAM_ADDR_BITS;

  word_t mem [DEPTH];   // Block RAM, no reset

  // Each byte lane written on its own
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_we[b])
        mem[ram_addr][b*8 +: 8] <= ram_wdata[b*8 +: 8];
    end
  end

  // Registered read every cycle, old data on a write to the same word
  always_ff @(posedge clk) begin
    ram_rdata <= mem[ram_addr];
  end

endmodule

//--- verilog/soc_io_pkg.sv
package soc_io_pkg;

  // Bus word and byte enables
  typedef logic [31:0] word_t;
  typedef logic [3:0]  wmask_t;

  // Address field positions
  localparam int PAGE_MSB = 31;   // Page select field
  localparam int PAGE_LSB = 30;
  localparam int MODE_MSB = 3;    // I/O write mode field
  localparam int MODE_LSB = 2;
  localparam int WORD_LSB = 2;    // Bits 1:0 are byte offset, ignored

  // Peripheral widths
  localparam int GPIO_WIDTH   = 28;
  localparam int LED_WIDTH    = 8;
  localparam int ANALOG_WIDTH = 12;  // Three 4-bit DAC channels

  // RAM word address width, 128 KB total
  localparam int RAM_ADDR_BITS = 15;

  // One-hot I/O register select bits
  localparam int IO_GPIO_IN_BIT    = 4;   // R
  localparam int IO_GPIO_OUT_BIT   = 5;   // RW, byte masked
  localparam int IO_GPIO_DIR_BIT   = 6;   // RW, byte masked, 1 means output
  localparam int IO_LEDS_BIT       = 7;   // RW
  localparam int IO_ANALOG_OUT_BIT = 15;  // RW
  localparam int IO_TICKS_BIT      = 18;  // RW, timer count
  localparam int IO_RELOAD_BIT     = 19;  // RW, timer reload

  // Page field of the address, bits 31:30
  typedef enum logic [1:0] {
    PAGE_RAM   = 2'b00,
    PAGE_IO    = 2'b01,
    PAGE_FLASH = 2'b10,   // Unmapped here, reads zero
    PAGE_SDRAM = 2'b11    // Unmapped here, reads zero
  } mem_page_t;

  // I/O write mode, address bits 3:2
  typedef enum logic [1:0] {
    MODE_WRITE  = 2'b00,
    MODE_CLEAR  = 2'b01,
    MODE_SET    = 2'b10,
    MODE_TOGGLE = 2'b11
  } io_mode_t;

endpackage

//--- verilog/soc_io_top.sv
module soc_io_top import soc_io_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  // Native processor bus
  input  word_t                   address,
  input  word_t                   wdata,
  input  wmask_t                  wmask,
  input  logic                    rstrb,
  output word_t                   rdata,       // Valid cycle after rstrb
  output logic                    interrupt,
  // Board I/O
  input  logic [GPIO_WIDTH-1:0]   gpio_in,
  output logic [GPIO_WIDTH-1:0]   gpio_out,
  output logic [GPIO_WIDTH-1:0]   gpio_dir,
  output logic [LED_WIDTH-1:0]    leds,
  output logic [ANALOG_WIDTH-1:0] analog_out
);

  // RAM path
  wmask_t                   ram_we;
  logic [RAM_ADDR_BITS-1:0] ram_addr;
  word_t                    ram_wdata;
  word_t                    ram_rdata;

  // I/O register path
  word_t  io_sel;
  wmask_t io_wmask;
  word_t  io_wdata_mod;
  word_t  ticks;
  word_t  reload;

  bus_control u_bus_control (
    .clk          (clk),
    .reset        (reset),
    .address      (address),
    .wdata        (wdata),
    .wmask        (wmask),
    .rstrb        (rstrb),
    .rdata        (rdata),
    .ram_we       (ram_we),
    .ram_addr     (ram_addr),
    .ram_wdata    (ram_wdata),
    .ram_rdata    (ram_rdata),
    .io_sel       (io_sel),
    .io_wmask     (io_wmask),
    .io_wdata_mod (io_wdata_mod),
    .gpio_in      (gpio_in),
    .gpio_out     (gpio_out),
    .gpio_dir     (gpio_dir),
    .leds         (leds),
    .analog_out   (analog_out),
    .ticks        (ticks),
    .reload       (reload)
  );

  ram_block u_ram_block (
    .clk       (clk),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  gpio_regs u_gpio_regs (
    .clk          (clk),
    .reset        (reset),
    .io_sel       (io_sel),
    .io_wmask     (io_wmask),
    .io_wdata_mod (io_wdata_mod),
    .gpio_out     (gpio_out),
    .gpio_dir     (gpio_dir),
    .leds         (leds),
    .analog_out   (analog_out)
  );

  // Timer takes raw bus data, not the mode result
  io_timer u_io_timer (
    .clk       (clk),
    .reset     (reset),
    .io_sel    (io_sel),
    .wdata     (wdata),
    .ticks     (ticks),
    .reload    (reload),
    .interrupt (interrupt)
  );

endmodule
